//--- bench/sdCardModel.sv
`timescale 1ns/1ns

module sdCardModel
    import sdPkg::*;
(
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);

    logic [7:0] inShift;
    logic [7:0] outByte = 8'hFF;
    logic [7:0] frame [0:5];      // Command frame as received
    logic [7:0] replyQueue [$];   // Bytes waiting to go out on miso
    int         bitCount = 0;
    int         frameCount = 0;
    int         opCondCount = 0;  // ACMD41 calls since CMD0
    bit         inIdle = 1'b1;
    bit         appNext = 1'b0;   // Previous command was CMD55

    initial begin
        miso = 1'b1;
    end

    // Block contents, byte k of sector s is 7s + k modulo 256
    function automatic logic [7:0] blockData(input logic [31:0] sector, input int k);
        logic [31:0] sum;
        sum = sector * 7 + k;
        return sum[7:0];
    endfunction

    task automatic handleCommand();
        logic [5:0]  index;
        logic [31:0] argument;
        logic [7:0]  r1;
        index    = frame[0][5:0];
        argument = {frame[1], frame[2], frame[3], frame[4]};
        replyQueue.push_back(8'hFF); // One byte of response latency
        case (index)
            goIdle: begin
                inIdle      = 1'b1;
                opCondCount = 0;
                r1          = 8'h01;
            end
            appCmd: r1 = {7'd0, inIdle};
            sendOpCond: begin
                if (appNext) begin
                    opCondCount = opCondCount + 1;
                    if (opCondCount >= 3) begin // Card leaves idle on the third try
                        inIdle = 1'b0;
                    end
                    r1 = {7'd0, inIdle};
                end else begin
                    r1 = 8'h04; // Illegal without CMD55
                end
            end
            readSingle: r1 = inIdle ? 8'h05 : 8'h00;
            default: r1 = 8'h04;
        endcase
        appNext = (index == appCmd);
        replyQueue.push_back(r1);
        if (index == readSingle && r1 == 8'h00) begin
            replyQueue.push_back(8'hFF); // Access time
            replyQueue.push_back(8'hFF);
            replyQueue.push_back(dataToken);
            for (int k = 0; k < blockBytes; k++) begin
                replyQueue.push_back(blockData(argument >> 9, k));
            end
            replyQueue.push_back(8'hA5); // CRC, never checked
            replyQueue.push_back(8'h5A);
        end
    endtask

    task automatic takeByte(input logic [7:0] value);
        // A frame starts with bits 01, idle fill bytes are all ones
        if (frameCount > 0 || value[7:6] == 2'b01) begin
            frame[frameCount] = value;
            frameCount = frameCount + 1;
            if (frameCount == 6) begin
                frameCount = 0;
                handleCommand();
            end
        end
    endtask

    // Sample mosi on rising sclk
    always @(posedge sclk) begin
        if (cs) begin
            bitCount   = 0;
            frameCount = 0;
            replyQueue.delete();
            outByte    = 8'hFF;
            miso       = 1'b1;
        end else begin
            inShift  = {inShift[6:0], mosi};
            bitCount = bitCount + 1;
        end
    end

    // Shift miso on falling sclk, next byte MSB is ready before its first rising edge
    always @(negedge sclk) begin
        if (bitCount == 8) begin
            bitCount = 0;
            takeByte(inShift);
            if (replyQueue.size() > 0) begin
                outByte = replyQueue.pop_front();
            end else begin
                outByte = 8'hFF;
            end
            miso = outByte[7];
        end else if (bitCount > 0) begin
            miso = outByte[7 - bitCount];
        end
    end

endmodule

//--- bench/sdReadGolden.txt
# kind sector(hex) wordIndex(decimal) expected(hex), block byte 0 in bits 7 to 0
# busyRead also pulses a second read while busy after done, which must be ignored
word     00000   0 03020100
word     00005 127 2221201F
word     00012  37 15141312
word     00123  64 F8F7F6F5
word     ABCDE  10 3D3C3B3A
busyRead 00007   2 3C3B3A39
word     00003   5 2C2B2A29
word     00040 100 53525150
word     00001  63 06050403
word     FFFFF 126 F4F3F2F1

//--- bench/sdReadTb.sv
`timescale 1ns/1ns

module sdReadTb;

    logic        Clock = 1'b0;
    logic        Reset = 1'b1;
    logic [31:0] address = '0;
    logic        read = 1'b0;
    logic [31:0] data;
    logic        done;
    logic        busy;
    logic        cs;
    logic        mosi;
    logic        miso;
    logic        sclk;

    int errorCount = 0;
    int checkCount = 0;
    int doneCount = 0;
    int waitLimit = 40000; // Cycles, a block read takes about 18000
    int seed = 32'hb122;

    always #50 Clock = ~Clock;

    sdReadTop i_sdReadTop (
        .Clock   (Clock),
        .Reset   (Reset),
        .address (address),
        .read    (read),
        .data    (data),
        .done    (done),
        .busy    (busy),
        .cs      (cs),
        .mosi    (mosi),
        .miso    (miso),
        .sclk    (sclk)
    );

    sdCardModel cardModel (
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi),
        .miso (miso)
    );

    always @(negedge Clock) begin
        if (done) begin
            doneCount <= doneCount + 1;
        end
    end

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount = checkCount + 1;
        if (actual !== expected) begin
            errorCount = errorCount + 1;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic waitBusyLow(input string phase, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        @(negedge Clock);
        while (busy !== 1'b0 && ok) begin
            if (cycles == waitLimit) begin
                errorCount = errorCount + 1;
                $display("Timeout: busy did not fall %s within %0d cycles", phase, waitLimit);
                ok = 1'b0;
            end else begin
                cycles = cycles + 1;
                @(negedge Clock);
            end
        end
    endtask

    task automatic waitDone(output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b1;
        @(negedge Clock);
        while (done !== 1'b1 && ok) begin
            if (cycles == waitLimit) begin
                errorCount = errorCount + 1;
                $display("Timeout: no done pulse within %0d cycles of a request", waitLimit);
                ok = 1'b0;
            end else begin
                cycles = cycles + 1;
                @(negedge Clock);
            end
        end
    endtask

    // One cycle read pulse, the ignored address bits get random filler
    task automatic issueRead(input logic [19:0] sector, input logic [6:0] index);
        logic [4:0] filler;
        filler = $random(seed);
        @(posedge Clock);
        address <= {sector, filler, index};
        read    <= 1'b1;
        @(posedge Clock);
        read <= 1'b0;
    endtask

    task automatic runRead(input logic [19:0] sector, input logic [6:0] index,
                           input logic [31:0] expected, input bit pulseWhileBusy,
                           output bit ok);
        int doneBefore;
        waitBusyLow("before a request", ok);
        doneBefore = doneCount;
        if (ok) begin
            issueRead(sector, index);
            waitDone(ok);
        end
        if (ok) begin
            checkValue("data at done", data, expected);
            if (pulseWhileBusy) begin
                checkValue("busy after done", busy, 1);
                issueRead(sector + 20'd1, index ^ 7'd1); // Must be ignored
            end
            waitBusyLow("after done", ok);
        end
        if (ok) begin
            checkValue("done pulses per request", doneCount - doneBefore, 1);
            checkValue("data held after busy falls", data, expected);
        end
    endtask

    initial begin
        int              fd;
        int              code;
        int              rows;
        int              wordIndex;
        int              ch;
        logic [8*16-1:0] kind;
        logic [19:0]     sector;
        logic [31:0]     expected;
        bit              ok;
        bit              more;

        @(posedge Clock);
        @(negedge Clock);
        checkValue("cs in reset", cs, 1);
        checkValue("sclk in reset", sclk, 0);
        checkValue("mosi in reset", mosi, 1);
        @(posedge Clock);
        Reset <= 1'b0;

        @(negedge Clock);
        checkValue("busy after reset", busy, 1);
        checkValue("done after reset", done, 0);
        waitBusyLow("during card initialisation", ok);

        rows = 0;
        fd = $fopen("bench/sdReadGolden.txt", "r");
        if (fd == 0) begin
            errorCount = errorCount + 1;
            $display("Could not open bench/sdReadGolden.txt");
        end
        more = ok && (fd != 0);
        while (more) begin
            kind = '0;
            if ($fscanf(fd, "%s", kind) != 1) begin
                more = 1'b0;
            end else if (kind == "word" || kind == "busyRead") begin
                code = $fscanf(fd, "%h %d %h", sector, wordIndex, expected);
                if (code != 3) begin
                    errorCount = errorCount + 1;
                    $display("Malformed request line in the golden file");
                    more = 1'b0;
                end else begin
                    rows = rows + 1;
                    runRead(sector, wordIndex[6:0], expected, kind == "busyRead", ok);
                    more = ok;
                end
            end else begin
                ch = $fgetc(fd); // Comment line, skip the rest
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (rows == 0) begin
            errorCount = errorCount + 1;
            $display("No requests were run from the golden file");
        end

        $display("Requests: %0d, checks: %0d, errors: %0d", rows, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/sdCardController.sv
`timescale 1ns/1ns

module sdCardController
    import sdPkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    input  logic        blockRead,
    input  logic [19:0] sectorAddress,
    output logic        ready,
    output logic        byteAvailable,
    output logic [7:0]  blockByte,
    output logic        start,
    output logic [7:0]  txByte,
    input  logic        byteDone,
    input  logic [7:0]  rxByte,
    input  logic        engineBusy,
    output logic        cs
);

    controllerState state;
    sdCommand       cmdIndex;
    logic [31:0]    argument;
    logic [9:0]     byteCount;   // Dummy, frame, block and CRC byte position
    logic [9:0]     pollCount;
    logic [7:0]     retryCount;  // ACMD41 attempts
    logic [7:0]     response;    // Last ACMD41 R1
    logic           pending;     // Byte in flight on the engine
    logic           exchange;
    logic [7:0]     frameByte;

    assign ready = (state == idle);

    // States that clock a byte through the engine
    assign exchange = (state == powerUp) || (state == sendCommand) ||
                      (state == waitResponse) || (state == waitToken) ||
                      (state == readBlock) || (state == skipCrc);

    always_comb begin
        case (byteCount[2:0])
            3'd0:    frameByte = {2'b01, cmdIndex};
            3'd1:    frameByte = argument[31:24];
            3'd2:    frameByte = argument[23:16];
            3'd3:    frameByte = argument[15:8];
            3'd4:    frameByte = argument[7:0];
            default: frameByte = (cmdIndex == goIdle) ? crcGoIdle : crcDefault;
        endcase
    end

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state         <= powerUp;
            cmdIndex      <= goIdle;
            argument      <= '0;
            byteCount     <= '0;
            pollCount     <= '0;
            retryCount    <= '0;
            response      <= '0;
            pending       <= 1'b0;
            start         <= 1'b0;
            byteAvailable <= 1'b0;
            cs            <= 1'b1;
        end else begin
            start         <= 1'b0;
            byteAvailable <= 1'b0;

            if (byteDone) begin
                pending <= 1'b0;
            end else if (exchange && !pending && !engineBusy) begin
                start   <= 1'b1;
                pending <= 1'b1;
            end

            case (state)
                powerUp: if (byteDone) begin
                    if (byteCount == powerUpBytes - 10'd1) begin
                        byteCount <= '0;
                        cs        <= 1'b0; // Card selected from CMD0 on
                        cmdIndex  <= goIdle;
                        argument  <= '0;
                        state     <= sendCommand;
                    end else begin
                        byteCount <= byteCount + 10'd1;
                    end
                end
                sendCommand: if (byteDone) begin
                    if (byteCount == commandBytes - 10'd1) begin
                        byteCount <= '0;
                        pollCount <= '0;
                        state     <= waitResponse;
                    end else begin
                        byteCount <= byteCount + 10'd1;
                    end
                end
                waitResponse: if (byteDone) begin
                    if (!rxByte[7]) begin // R1 has a zero start bit
                        case (cmdIndex)
                            goIdle: begin
                                cmdIndex <= appCmd;
                                state    <= (rxByte == r1Idle) ? sendCommand : fault;
                            end
                            appCmd: begin
                                cmdIndex <= sendOpCond;
                                state    <= sendCommand;
                            end
                            sendOpCond: begin
                                response <= rxByte;
                                state    <= initCheck;
                            end
                            default: begin
                                pollCount <= '0;
                                state     <= (rxByte == 8'h00) ? waitToken : fault;
                            end
                        endcase
                    end else if (pollCount == responseWaitLimit - 10'd1) begin
                        state <= fault;
                    end else begin
                        pollCount <= pollCount + 10'd1;
                    end
                end
                initCheck: begin
                    if (response == 8'h00) begin
                        state <= idle;
                    end else if (retryCount == initRetryLimit - 8'd1) begin
                        state <= fault;
                    end else begin
                        retryCount <= retryCount + 8'd1;
                        cmdIndex   <= appCmd;
                        state      <= sendCommand;
                    end
                end
                idle: begin
                    retryCount <= '0;
                    if (blockRead) begin
                        cmdIndex  <= readSingle;
                        argument  <= {3'b000, sectorAddress, 9'd0}; // Byte address
                        byteCount <= '0;
                        state     <= sendCommand;
                    end
                end
                waitToken: if (byteDone) begin
                    if (rxByte == dataToken) begin
                        byteCount <= '0;
                        state     <= readBlock;
                    end else if (rxByte != fillByte) begin
                        state <= fault; // Data error token
                    end else if (pollCount == responseWaitLimit - 10'd1) begin
                        state <= fault;
                    end else begin
                        pollCount <= pollCount + 10'd1;
                    end
                end
                readBlock: if (byteDone) begin
                    byteAvailable <= 1'b1;
                    if (byteCount == blockBytes - 10'd1) begin
                        byteCount <= '0;
                        state     <= skipCrc;
                    end else begin
                        byteCount <= byteCount + 10'd1;
                    end
                end
                skipCrc: if (byteDone) begin
                    if (byteCount == crcBytes - 10'd1) begin
                        byteCount <= '0;
                        state     <= idle;
                    end else begin
                        byteCount <= byteCount + 10'd1;
                    end
                end
                default: begin // fault, start over with the card deselected
                    cs         <= 1'b1;
                    byteCount  <= '0;
                    pollCount  <= '0;
                    retryCount <= '0;
                    state      <= powerUp;
                end
            endcase
        end
    end

    // Byte payload toward engine and reader
    always_ff @(posedge Clock) begin
        if (exchange && !pending && !engineBusy && !byteDone) begin
            txByte <= (state == sendCommand) ? frameByte : fillByte;
        end
        if (state == readBlock && byteDone) begin
            blockByte <= rxByte;
        end
    end

    // Reader handshake, a block request only lands in idle
    readOnlyWhenReady: assert property (@(posedge Clock) disable iff (Reset)
        blockRead |-> ready)
        else $error("blockRead while controller not ready");

endmodule

//--- logic/sdPkg.sv
package sdPkg;

    // SPI clock timing
    localparam logic [3:0] spiHalfPeriod = 4'd2;  // Clock cycles per sclk half period
    localparam logic [3:0] lastSclkEdge  = 4'd15; // 16 sclk edges per byte

    // Byte counts, all sized for the 10-bit byte counter
    localparam logic [9:0] powerUpBytes = 10'd10;  // Dummy bytes with cs high
    localparam logic [9:0] commandBytes = 10'd6;   // Command frame length
    localparam logic [9:0] blockBytes   = 10'd512;
    localparam logic [9:0] crcBytes     = 10'd2;

    // Retry and polling limits
    localparam logic [7:0] initRetryLimit    = 8'd200;  // ACMD41 attempts before restart
    localparam logic [9:0] responseWaitLimit = 10'd500; // 0xFF polls for R1 or token

    // Fixed protocol bytes
    localparam logic [7:0] dataToken  = 8'hFE;
    localparam logic [7:0] fillByte   = 8'hFF; // Sent while reading
    localparam logic [7:0] r1Idle     = 8'h01; // Expected CMD0 answer
    localparam logic [7:0] crcGoIdle  = 8'h95; // Valid CRC for CMD0 with zero argument
    localparam logic [7:0] crcDefault = 8'h01; // Only the stop bit, CRC not checked in SPI

    // Command indices
    typedef enum logic [5:0] {
        goIdle     = 6'd0,
        readSingle = 6'd17,
        sendOpCond = 6'd41,
        appCmd     = 6'd55
    } sdCommand;

    typedef enum logic [3:0] {
        powerUp,
        sendCommand,
        waitResponse,
        initCheck,
        idle,
        waitToken,
        readBlock,
        skipCrc,
        fault
    } controllerState;

    // Reader idle carries a prefix, enum literals share the package scope
    typedef enum logic [1:0] {
        readerIdle,
        skipping,
        collecting,
        draining
    } readerState;

endpackage

//--- logic/sdReadTop.sv
`timescale 1ns/1ns

module sdReadTop (
    input  logic        Clock,
    input  logic        Reset,
    input  logic [31:0] address,
    input  logic        read,
    output logic [31:0] data,
    output logic        done,
    output logic        busy,
    output logic        cs,
    output logic        mosi,
    input  logic        miso,
    output logic        sclk
);

    logic        blockRead;
    logic [19:0] sectorAddress;
    logic        ready;
    logic        byteAvailable;
    logic [7:0]  blockByte;
    logic        start;
    logic [7:0]  txByte;
    logic [7:0]  rxByte;
    logic        byteDone;
    logic        engineBusy;

    // Host side word selection
    sdWordReader i_sdWordReader (
        .Clock         (Clock),
        .Reset         (Reset),
        .address       (address),
        .read          (read),
        .data          (data),
        .done          (done),
        .busy          (busy),
        .blockRead     (blockRead),
        .sectorAddress (sectorAddress),
        .ready         (ready),
        .byteAvailable (byteAvailable),
        .blockByte     (blockByte)
    );

    sdCardController i_sdCardController (
        .Clock         (Clock),
        .Reset         (Reset),
        .blockRead     (blockRead),
        .sectorAddress (sectorAddress),
        .ready         (ready),
        .byteAvailable (byteAvailable),
        .blockByte     (blockByte),
        .start         (start),
        .txByte        (txByte),
        .byteDone      (byteDone),
        .rxByte        (rxByte),
        .engineBusy    (engineBusy),
        .cs            (cs)
    );

    // Card pins except cs
    spiByteEngine i_spiByteEngine (
        .Clock      (Clock),
        .Reset      (Reset),
        .start      (start),
        .txByte     (txByte),
        .rxByte     (rxByte),
        .byteDone   (byteDone),
        .engineBusy (engineBusy),
        .sclk       (sclk),
        .mosi       (mosi),
        .miso       (miso)
    );

endmodule

//--- logic/sdWordReader.sv
`timescale 1ns/1ns

module sdWordReader
    import sdPkg::*;
(
    input  logic        Clock,
    input  logic        Reset,
    input  logic [31:0] address,
    input  logic        read,
    output logic [31:0] data,
    output logic        done,
    output logic        busy,
    output logic        blockRead,
    output logic [19:0] sectorAddress,
    input  logic        ready,
    input  logic        byteAvailable,
    input  logic [7:0]  blockByte
);

    readerState state;
    logic [6:0] wordIndex;
    logic [8:0] byteOffset; // Position in the 512-byte block
    logic       wanted;

    // Busy also covers card initialisation
    assign busy = (state != readerIdle) || !ready;

    // Current byte belongs to the requested word
    assign wanted = (byteOffset[8:2] == wordIndex);

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            state      <= readerIdle;
            byteOffset <= '0;
            blockRead  <= 1'b0;
            done       <= 1'b0;
        end else begin
            blockRead <= 1'b0;
            done      <= 1'b0;
            case (state)
                readerIdle: begin
                    if (read && !busy) begin
                        blockRead  <= 1'b1;
                        byteOffset <= '0;
                        state      <= skipping;
                    end
                end
                skipping, collecting: begin
                    if (byteAvailable) begin
                        byteOffset <= byteOffset + 9'd1;
                        if (wanted) begin
                            if (byteOffset[1:0] == 2'd3) begin
                                done  <= 1'b1; // Fourth byte in
                                state <= draining;
                            end else begin
                                state <= collecting;
                            end
                        end
                    end
                end
                default: begin
                    // Remaining bytes and CRC pass by
                    if (ready) begin
                        state <= readerIdle;
                    end
                end
            endcase
        end
    end

    // Request payload and word assembly
    always_ff @(posedge Clock) begin
        if (state == readerIdle && read && !busy) begin
            wordIndex     <= address[6:0];
            sectorAddress <= address[31:12];
        end
        if ((state == skipping || state == collecting) && byteAvailable && wanted) begin
            data[{byteOffset[1:0], 3'b000} +: 8] <= blockByte; // Byte 0 lands low
        end
    end

    // One pulse per request
    singleDonePulse: assert property (@(posedge Clock) disable iff (Reset)
        done |=> !done)
        else $error("done high for more than one cycle");

endmodule

//--- logic/spiByteEngine.sv
`timescale 1ns/1ns

module spiByteEngine
    import sdPkg::*;
(
    input  logic       Clock,
    input  logic       Reset,
    input  logic       start,
    input  logic [7:0] txByte,
    output logic [7:0] rxByte,
    output logic       byteDone,
    output logic       engineBusy,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);

    logic [3:0] divCount;  // Counts Clock cycles within a half period
    logic [3:0] edgeCount; // sclk edge number within the byte
    logic [7:0] txShift;
    logic [7:0] rxShift;
    logic       halfDone;
    logic       lastEdge;

    assign halfDone = engineBusy && (divCount == spiHalfPeriod - 4'd1);
    assign lastEdge = halfDone && (edgeCount == lastSclkEdge); // Final falling edge

    always_ff @(posedge Clock or posedge Reset) begin
        if (Reset) begin
            engineBusy <= 1'b0;
            byteDone   <= 1'b0;
            sclk       <= 1'b0;
            mosi       <= 1'b1;
            divCount   <= '0;
            edgeCount  <= '0;
        end else begin
            byteDone <= 1'b0;
            if (!engineBusy) begin
                if (start) begin
                    engineBusy <= 1'b1;
                    divCount   <= '0;
                    edgeCount  <= '0;
                    mosi       <= txByte[7]; // Mode 0, MSB valid before first rising edge
                end
            end else if (halfDone) begin
                divCount  <= '0;
                sclk      <= ~sclk;
                edgeCount <= edgeCount + 4'd1;
                if (sclk) begin
                    // Falling edge, next bit out; fill ones leave mosi idling high
                    mosi <= txShift[6];
                end
                if (lastEdge) begin
                    engineBusy <= 1'b0;
                    byteDone   <= 1'b1;
                end
            end else begin
                divCount <= divCount + 4'd1;
            end
        end
    end

    // Shift registers
    always_ff @(posedge Clock) begin
        if (!engineBusy && start) begin
            txShift <= txByte;
        end else if (halfDone) begin
            if (sclk) begin
                txShift <= {txShift[6:0], 1'b1};
            end else begin
                rxShift <= {rxShift[6:0], miso}; // Sample on rising edge
            end
        end
        if (lastEdge) begin
            rxByte <= rxShift;
        end
    end

    // The controller must wait for the current byte to finish
    startWhileBusy: assert property (@(posedge Clock) disable iff (Reset)
        start |-> !engineBusy)
        else $error("SPI byte start while engine busy");

endmodule

//--- sdReadTop.f
logic/sdPkg.sv
logic/spiByteEngine.sv
logic/sdCardController.sv
logic/sdWordReader.sv
logic/sdReadTop.sv
bench/sdCardModel.sv
bench/sdReadTb.sv
